// File: verification/apb_uart_patterns.txt
# kind addr strb data exp_data exp_err in hex; kind 0 write, 1 read, 2 rxd frame, 3 wait
# read strb 1 expects last rxd byte; rxd strb bit 0 bad parity, 1 low stop, 2 random; wait strb 1 irq
# reset values
1 000 0 00000000 00000000 0
1 004 0 00000000 00000000 0
1 008 0 00000000 00000000 0
1 00C 0 00000000 00000004 0
1 010 0 00000000 00000020 0
1 01C 0 00000000 00000000 0
1 020 0 00000000 00000000 0
1 024 0 00000000 00000000 0
# byte strobes
0 008 2 1111AB11 00000000 0
1 008 0 00000000 0000AB00 0
0 020 4 22CD2222 00000000 0
1 020 0 00000000 00CD0000 0
0 00C 8 7F333333 00000000 0
1 00C 0 00000000 7F000004 0
# error responses
1 014 0 00000000 00000000 1
1 018 0 00000000 00000000 1
1 0FC 0 00000000 00000000 1
0 010 F 000000FF 00000000 1
# loopback
0 01C F 00000010 00000000 0
0 020 F 00000001 00000000 0
3 010 0 00000020 00000020 0
0 000 1 0000005A 00000000 0
3 000 1 00000000 00000001 0
3 010 0 00000021 00000021 0
1 010 0 00000000 00000021 0
1 024 0 00000000 00000001 0
1 004 0 00000000 0000005A 0
1 010 0 00000000 00000020 0
1 024 0 00000000 00000000 0
# transmit framing, even parity
0 01C F 00000000 00000000 0
0 020 F 00000000 00000000 0
0 008 1 00000018 00000000 0
1 008 0 00000000 0000AB18 0
0 000 1 00000001 00000000 0
3 010 0 00000020 00000020 0
0 000 1 000000C3 00000000 0
3 010 0 00000020 00000020 0
# receive errors
2 000 1 00000096 00000000 0
3 010 0 00000001 00000001 0
1 010 0 00000000 00000025 0
1 004 0 00000000 00000096 0
2 000 2 0000003C 00000000 0
3 010 0 00000001 00000001 0
1 010 0 00000000 00000029 0
1 004 0 00000000 0000003C 0
2 000 4 00000000 00000000 0
3 010 0 00000001 00000001 0
1 010 0 00000000 00000021 0
1 004 1 00000000 00000000 0

// File: sim.f
+incdir+source
source/uart_package.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/apb_uart_regs.sv
source/apb_uart_top.sv
verification/apb_uart_checker.sv
verification/apb_uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
  --top-module apb_uart_tb -o apb_uart_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/apb_uart_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: verification/apb_uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module apb_uart_tb;
  import uart_package::*;

  localparam int DW         = `UART_DATA_WIDTH;
  localparam int AW         = `UART_ADDR_WIDTH;
  localparam int WAIT_LIMIT = 2000;

  logic            apb_if, rst_n;
  logic            psel, penable, pwrite;
  logic [AW-1:0]   paddr;
  logic [DW-1:0]   pwdata;
  logic [DW/8-1:0] pstrb;
  logic            pready, pslverr;
  logic [DW-1:0]   prdata;
  logic            rxd, txd, irq;

  // expectations for the checker
  logic            exp_valid, exp_err, exp_tx_push;
  logic [DW-1:0]   exp_data;
  logic [7:0]      exp_tx_byte;
  logic [DW-1:0]   tdr_model, lcr_model, ocr_model, mcr_model;
  logic [31:0]     chk_errors, chk_count, tx_pending;

  int              tb_errors;
  int              cycle_count = 0;
  integer          seed;
  logic [7:0]      last_sent;

  initial begin
    apb_if = 1'b0;
    forever #5 apb_if = ~apb_if;
  end

  always @(posedge apb_if) cycle_count <= cycle_count + 1;

  apb_uart_top uut (
    .apb_if(apb_if), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .pready(pready), .prdata(prdata), .pslverr(pslverr),
    .rxd(rxd), .txd(txd), .irq(irq)
  );

  apb_uart_checker u_checker (
    .apb_if(apb_if), .rst_n(rst_n), .pready(pready), .paddr(paddr),
    .prdata(prdata), .pslverr(pslverr), .txd(txd),
    .exp_valid(exp_valid), .exp_data(exp_data), .exp_err(exp_err),
    .exp_tx_push(exp_tx_push), .exp_tx_byte(exp_tx_byte),
    .exp_lcr(lcr_model), .exp_divisor(ocr_model[15:0]),
    .error_count(chk_errors), .check_count(chk_count), .tx_pending(tx_pending)
  );

  function automatic logic [DW-1:0] apply_strobes(input logic [DW-1:0]   old_val,
                                                  input logic [DW-1:0]   new_val,
                                                  input logic [DW/8-1:0] strb);
    logic [DW-1:0] lane_mask;
    for (int i = 0; i < DW/8; i++) begin
      lane_mask[8*i +: 8] = {8{strb[i]}};
    end
    return (old_val & ~lane_mask) | (new_val & lane_mask);
  endfunction

  // bit that brings the count of ones to even or odd
  function automatic logic parity_bit(input logic [7:0] value, input logic even);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (value[i]) ones++;
    end
    return even ? ones[0] : !ones[0];
  endfunction

  // --------------------
  // apb driver, one setup and one access phase
  task automatic apb_transfer(input logic wr, input logic [AW-1:0] addr,
                              input logic [DW/8-1:0] strb, input logic [DW-1:0] data,
                              input logic check, input logic [DW-1:0] exp_d,
                              input logic exp_e, input logic push,
                              output logic [DW-1:0] rdata);
    int waited;
    @(posedge apb_if);
    #1;
    psel        = 1'b1;
    penable     = 1'b0;
    pwrite      = wr;
    paddr       = addr;
    pwdata      = wr ? data : '0;
    pstrb       = wr ? strb : '0;
    exp_valid   = check;
    exp_data    = exp_d;
    exp_err     = exp_e;
    exp_tx_push = push;
    @(posedge apb_if);
    #1;
    penable     = 1'b1;
    exp_tx_push = 1'b0;
    waited      = 0;
    @(posedge apb_if);
    while (!pready && waited < 16) begin
      @(posedge apb_if);
      waited++;
    end
    rdata = prdata;
    if (!pready) begin
      tb_errors++;
      $display("no pready from the DUT for address %h at %0t", addr, $time);
    end
    #1;
    psel      = 1'b0;
    penable   = 1'b0;
    exp_valid = 1'b0;
  endtask

  // one frame on rxd at the current divisor and line settings
  task automatic send_serial(input logic [7:0] value, input logic bad_parity,
                             input logic low_stop);
    logic [15:0] div;
    logic [10:0] frame;
    int          bit_clocks;
    int          nbits;
    div = ocr_model[15:0];
    if (div == 16'd0) div = 16'd1;
    bit_clocks = 16 * int'(div);
    frame      = '1;
    frame[0]   = 1'b0;
    frame[8:1] = value;
    nbits      = 10;
    if (lcr_model[`UART_LCR_PEN]) begin
      frame[9] = parity_bit(value, lcr_model[`UART_LCR_EPS]) ^ bad_parity;
      nbits    = 11;
    end
    frame[nbits-1] = !low_stop;
    for (int i = 0; i < nbits; i++) begin
      @(posedge apb_if);
      #1 rxd = frame[i];
      repeat (bit_clocks - 1) @(posedge apb_if);
    end
    @(posedge apb_if);
    #1 rxd = 1'b1;
    repeat (bit_clocks) @(posedge apb_if);  // idle gap
  endtask

  task automatic wait_ready(input logic [AW-1:0] addr, input logic on_irq,
                            input logic [DW-1:0] mask, input logic [DW-1:0] value,
                            input int line_no);
    int            start;
    logic          done;
    logic [DW-1:0] rdata;
    start = cycle_count;
    done  = 1'b0;
    while (!done && (cycle_count - start) < WAIT_LIMIT) begin
      if (on_irq) begin
        @(posedge apb_if);
        done = (irq == value[0]);
      end else begin
        apb_transfer(1'b0, addr, '0, '0, 1'b0, '0, 1'b0, 1'b0, rdata);
        done = ((rdata & mask) == value);
      end
    end
    if (!done) begin
      tb_errors++;
      $display("wait at pattern line %0d timed out after %0d cycles", line_no, WAIT_LIMIT);
    end
  endtask

  task automatic run_pattern(input logic [31:0] kind, input logic [31:0] addr,
                             input logic [31:0] strb, input logic [31:0] data,
                             input logic [31:0] exp_d, input logic [31:0] exp_e,
                             input int line_no);
    logic [DW-1:0] rdata;
    logic [DW-1:0] exp_read;
    logic [7:0]    value;
    logic          is_tdr;
    case (kind)
      32'h0: begin
        is_tdr = (addr[AW-1:0] == ADDR_TDR);
        if (is_tdr) begin
          tdr_model   = apply_strobes(tdr_model, data, strb[DW/8-1:0]);
          exp_tx_byte = tdr_model[7:0];
        end
        apb_transfer(1'b1, addr[AW-1:0], strb[DW/8-1:0], data, 1'b1, '0, exp_e[0],
                     is_tdr && !mcr_model[`UART_MCR_LOOP], rdata);
        if (addr[AW-1:0] == ADDR_LCR) lcr_model = apply_strobes(lcr_model, data, strb[3:0]);
        if (addr[AW-1:0] == ADDR_OCR) ocr_model = apply_strobes(ocr_model, data, strb[3:0]);
        if (addr[AW-1:0] == ADDR_MCR) mcr_model = apply_strobes(mcr_model, data, strb[3:0]);
      end
      32'h1: begin
        exp_read = strb[0] ? {24'd0, last_sent} : exp_d;
        apb_transfer(1'b0, addr[AW-1:0], '0, '0, 1'b1, exp_read, exp_e[0], 1'b0, rdata);
      end
      32'h2: begin
        value     = strb[2] ? 8'($random(seed)) : data[7:0];
        last_sent = value;
        send_serial(value, strb[0], strb[1]);
      end
      32'h3: wait_ready(addr[AW-1:0], strb[0], data, exp_d, line_no);
      default: begin
        tb_errors++;
        $display("unknown pattern kind %h on line %0d", kind, line_no);
      end
    endcase
  endtask

  // --------------------
  initial begin
    int          fd, code, line_no, waited;
    string       line;
    logic [31:0] kind, addr, strb, data, exp_d, exp_e;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pstrb       = '0;
    rxd         = 1'b1;
    rst_n       = 1'b0;
    exp_valid   = 1'b0;
    exp_data    = '0;
    exp_err     = 1'b0;
    exp_tx_push = 1'b0;
    exp_tx_byte = '0;
    tdr_model   = '0;
    lcr_model   = '0;
    mcr_model   = '0;
    ocr_model   = DW'(`UART_RESET_DIVISOR);
    tb_errors   = 0;
    seed        = 32'h2faa;
    last_sent   = '0;
    repeat (16) @(posedge apb_if);
    #1 rst_n = 1'b1;

    fd = $fopen("verification/apb_uart_patterns.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("could not open the pattern file");
    end else begin
      line_no = 0;
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        line_no++;
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h %h %h", kind, addr, strb, data, exp_d, exp_e);
          if (code == 6) begin
            run_pattern(kind, addr, strb, data, exp_d, exp_e, line_no);
          end else begin
            tb_errors++;
            $display("pattern line %0d could not be parsed", line_no);
          end
        end
      end
      $fclose(fd);
    end

    // let the last frames drain
    waited = 0;
    while (tx_pending != 0 && waited < WAIT_LIMIT) begin
      @(posedge apb_if);
      waited++;
    end
    if (tx_pending != 0) begin
      tb_errors++;
      $display("%0d bytes written to tdr never appeared on txd", tx_pending);
    end
    repeat (4) @(posedge apb_if);

    $display("checks %0d, checker errors %0d, testbench errors %0d",
             chk_count, chk_errors, tb_errors);
    if (tb_errors == 0 && chk_errors == 0 && chk_count != 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/apb_uart_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module apb_uart_checker (
  input  logic                        apb_if,
  input  logic                        rst_n,
  input  logic                        pready,
  input  logic [`UART_ADDR_WIDTH-1:0] paddr,
  input  logic [`UART_DATA_WIDTH-1:0] prdata,
  input  logic                        pslverr,
  input  logic                        txd,
  input  logic                        exp_valid,
  input  logic [`UART_DATA_WIDTH-1:0] exp_data,
  input  logic                        exp_err,
  input  logic                        exp_tx_push,
  input  logic [7:0]                  exp_tx_byte,
  input  logic [`UART_DATA_WIDTH-1:0] exp_lcr,
  input  logic [15:0]                 exp_divisor,
  output logic [31:0]                 error_count,
  output logic [31:0]                 check_count,
  output logic [31:0]                 tx_pending
);

  logic [7:0]  tx_queue[$];
  int          errors = 0;
  int          checks = 0;
  logic        line_q;
  logic        busy;
  logic        par_en, par_even;
  int          div_eff, wait_cnt, bit_pos, frame_len;
  logic [10:0] frame;  // start, data, parity, stop as sampled

  assign error_count = errors;
  assign check_count = checks;

  task automatic finish_frame();
    logic [7:0] expected;
    int         ones;
    checks++;
    if (tx_queue.size() == 0) begin
      errors++;
      $display("a frame appeared on txd at %0t with no byte written to tdr", $time);
    end else begin
      expected = tx_queue.pop_front();
      if (frame[8:1] !== expected) begin
        errors++;
        $display("FAILED at %0t: txd carried %h, expected %h", $time, frame[8:1], expected);
      end
      if (frame[0] !== 1'b0 || frame[frame_len-1] !== 1'b1) begin
        errors++;
        $display("FAILED at %0t: bad start or stop bit on txd for byte %h", $time, expected);
      end
      if (par_en) begin
        ones = 0;
        for (int i = 1; i < 10; i++) begin
          if (frame[i]) ones++;
        end
        if (ones[0] == par_even) begin  // even wants an even count
          errors++;
          $display("FAILED at %0t: wrong parity bit on txd for byte %h", $time, expected);
        end
      end
    end
  endtask

  always @(posedge apb_if) begin
    if (exp_tx_push) tx_queue.push_back(exp_tx_byte);

    // --------------------
    // apb responses
    if (pready && exp_valid) begin
      checks++;
      if (prdata !== exp_data) begin
        errors++;
        $display("FAILED at %0t: prdata at %h is %h, expected %h",
                 $time, paddr, prdata, exp_data);
      end
      if (pslverr !== exp_err) begin
        errors++;
        $display("FAILED at %0t: pslverr at %h is %b, expected %b",
                 $time, paddr, pslverr, exp_err);
      end
    end

    // --------------------
    // txd frame decoder, mid-bit sampling
    if (!rst_n) begin
      busy   = 1'b0;
      line_q = 1'b1;
    end else if (!busy) begin
      if (line_q && !txd) begin
        busy      = 1'b1;
        bit_pos   = 0;
        par_en    = exp_lcr[`UART_LCR_PEN];
        par_even  = exp_lcr[`UART_LCR_EPS];
        frame_len = par_en ? 11 : 10;
        div_eff   = (exp_divisor == 16'd0) ? 1 : int'(exp_divisor);
        wait_cnt  = 8 * div_eff - 1;  // middle of the start bit
        frame     = '1;
      end
    end else if (wait_cnt > 1) begin
      wait_cnt--;
    end else begin
      frame[bit_pos] = txd;
      bit_pos++;
      wait_cnt = 16 * div_eff;
      if (bit_pos == frame_len) begin
        busy = 1'b0;
        finish_frame();
      end
    end
    line_q = txd;
    tx_pending <= tx_queue.size();
  end

endmodule

`default_nettype wire

// File: source/apb_uart_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module apb_uart_top (
  input  logic                           apb_if,
  input  logic                           rst_n,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [`UART_ADDR_WIDTH-1:0]    paddr,
  input  logic [`UART_DATA_WIDTH-1:0]    pwdata,
  input  logic [`UART_DATA_WIDTH/8-1:0]  pstrb,
  output logic                           pready,
  output logic [`UART_DATA_WIDTH-1:0]    prdata,
  output logic                           pslverr,
  input  logic                           rxd,
  output logic                           txd,
  output logic                           irq
);

  logic        tick, tx_start, tx_busy, tx_serial;
  logic [7:0]  tx_data, rx_data;
  logic        parity_en, parity_even, loopback;
  logic [15:0] divisor;
  logic        rx_valid, rx_parity_err, rx_frame_err;
  logic        rx_in;

  // loopback keeps the line idle
  assign rx_in = loopback ? tx_serial : rxd;
  assign txd   = loopback ? 1'b1 : tx_serial;

  apb_uart_regs u_regs (
    .apb_if(apb_if), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .tx_busy(tx_busy), .rx_valid(rx_valid), .rx_data(rx_data),
    .rx_parity_err(rx_parity_err), .rx_frame_err(rx_frame_err),
    .pready(pready), .prdata(prdata), .pslverr(pslverr),
    .tx_start(tx_start), .tx_data(tx_data),
    .parity_en(parity_en), .parity_even(parity_even),
    .divisor(divisor), .loopback(loopback), .irq(irq)
  );

  uart_baud_gen u_baud (
    .apb_if(apb_if), .rst_n(rst_n), .divisor(divisor), .tick(tick)
  );

  uart_tx u_tx (
    .apb_if(apb_if), .rst_n(rst_n), .tick(tick),
    .tx_start(tx_start), .tx_data(tx_data),
    .parity_en(parity_en), .parity_even(parity_even),
    .tx_serial(tx_serial), .tx_busy(tx_busy)
  );

  uart_rx u_rx (
    .apb_if(apb_if), .rst_n(rst_n), .tick(tick), .rx_serial(rx_in),
    .parity_en(parity_en), .parity_even(parity_even),
    .rx_valid(rx_valid), .rx_data(rx_data),
    .rx_parity_err(rx_parity_err), .rx_frame_err(rx_frame_err)
  );

endmodule

`default_nettype wire

// File: source/apb_uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module apb_uart_regs (
  input  logic                           apb_if,
  input  logic                           rst_n,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [`UART_ADDR_WIDTH-1:0]    paddr,
  input  logic [`UART_DATA_WIDTH-1:0]    pwdata,
  input  logic [`UART_DATA_WIDTH/8-1:0]  pstrb,
  input  logic                           tx_busy,
  input  logic                           rx_valid,
  input  logic [7:0]                     rx_data,
  input  logic                           rx_parity_err,
  input  logic                           rx_frame_err,
  output logic                           pready,
  output logic [`UART_DATA_WIDTH-1:0]    prdata,
  output logic                           pslverr,
  output logic                           tx_start,
  output logic [7:0]                     tx_data,
  output logic                           parity_en,
  output logic                           parity_even,
  output logic [15:0]                    divisor,
  output logic                           loopback,
  output logic                           irq
);
  import uart_package::*;

  localparam int DW = `UART_DATA_WIDTH;
  localparam int NB = DW / 8;

  apb_state_e state, next_state;

  logic [DW-1:0] tdr, lcr, ocr, mcr, ier;
  logic [7:0]    rdr;
  logic          data_ready, parity_err, frame_err;
  logic [DW-1:0] lsr, iir;
  logic [DW-1:0] rd_data;
  logic          acc_err;
  logic          setup_cycle, wr_cycle, rd_rdr, tx_idle;

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_val,
                                                input logic [DW-1:0] new_val,
                                                input logic [NB-1:0] strb);
    logic [DW-1:0] res;
    res = old_val;
    for (int i = 0; i < NB; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // apb phase tracking
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = IDLE;
    case (state)
      IDLE: begin
        if (psel && !penable) next_state = SETUP;
      end
      SETUP: begin
        if (psel && penable) begin
          next_state = ACCESS;
        end else if (psel) begin
          next_state = SETUP;
        end
      end
      ACCESS: begin
        if (psel && !penable) next_state = SETUP;  // back to back
      end
      default: next_state = IDLE;
    endcase
  end

  // the cycle now on the bus is a setup phase
  assign setup_cycle = (next_state == SETUP);
  assign wr_cycle    = setup_cycle & pwrite;
  assign rd_rdr      = setup_cycle & ~pwrite & (paddr == ADDR_RDR);
  assign pready      = psel & penable;

  // --------------------
  // register writes
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      tdr <= '0;
      lcr <= '0;
      ocr <= DW'(`UART_RESET_DIVISOR);
      mcr <= '0;
      ier <= '0;
    end else if (wr_cycle) begin
      case (paddr)
        ADDR_TDR: tdr <= merge_bytes(tdr, pwdata, pstrb);
        ADDR_LCR: lcr <= merge_bytes(lcr, pwdata, pstrb);
        ADDR_OCR: ocr <= merge_bytes(ocr, pwdata, pstrb);
        ADDR_MCR: mcr <= merge_bytes(mcr, pwdata, pstrb);
        ADDR_IER: ier <= merge_bytes(ier, pwdata, pstrb);
        default: ;
      endcase
    end
  end

  // frame start, only when the transmitter can take it
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= wr_cycle && (paddr == ADDR_TDR) && !tx_busy && !tx_start;
    end
  end

  // receive status
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      rdr        <= '0;
      data_ready <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end else if (rx_valid) begin  // new byte wins over a read
      rdr        <= rx_data;
      data_ready <= 1'b1;
      parity_err <= rx_parity_err;
      frame_err  <= rx_frame_err;
    end else if (rd_rdr) begin
      data_ready <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end
  end

  assign tx_idle = ~tx_busy & ~tx_start;

  always_comb begin
    lsr = '0;
    lsr[`UART_LSR_DR]   = data_ready;
    lsr[`UART_LSR_PE]   = parity_err;
    lsr[`UART_LSR_FE]   = frame_err;
    lsr[`UART_LSR_TEMT] = tx_idle;
    iir = '0;
    iir[`UART_IER_RX] = data_ready & ier[`UART_IER_RX];
    iir[`UART_IER_TX] = tx_idle & ier[`UART_IER_TX];
  end

  assign irq = |iir;

  // --------------------
  // read mux and error decode
  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (paddr)
      ADDR_TDR: rd_data = tdr;
      ADDR_RDR: rd_data = {{(DW-8){1'b0}}, rdr};
      ADDR_LCR: rd_data = lcr;
      ADDR_OCR: rd_data = ocr;
      ADDR_LSR: rd_data = lsr;
      ADDR_MCR: rd_data = mcr;
      ADDR_IER: rd_data = ier;
      ADDR_IIR: rd_data = iir;
      default:  acc_err = 1'b1;  // fcr, msr, unmapped
    endcase
    if (pwrite) begin
      rd_data = '0;
      if (paddr == ADDR_RDR || paddr == ADDR_LSR || paddr == ADDR_IIR) begin
        acc_err = 1'b1;  // read-only
      end
    end
  end

  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else if (setup_cycle) begin
      prdata  <= rd_data;
      pslverr <= acc_err;
    end else begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end
  end

  assign tx_data     = tdr[7:0];
  assign parity_en   = lcr[`UART_LCR_PEN];
  assign parity_even = lcr[`UART_LCR_EPS];
  assign divisor     = ocr[15:0];
  assign loopback    = mcr[`UART_MCR_LOOP];

  // --------------------
  a_setup_first: assert property (@(posedge apb_if) disable iff (!rst_n)
    $rose(penable) |-> $past(psel))
    else $error("penable rose without a setup phase");

  a_start_idle: assert property (@(posedge apb_if) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  logic       apb_if,
  input  logic       rst_n,
  input  logic       tick,
  input  logic       rx_serial,
  input  logic       parity_en,
  input  logic       parity_even,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       rx_parity_err,
  output logic       rx_frame_err
);
  import uart_package::*;

  rx_state_e  state;
  logic [1:0] sync_q;
  logic       line_q;
  logic       falling;
  logic [3:0] tick_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  logic       par_err_q;
  logic       exp_par;
  logic       mid_start, mid_bit;

  // --------------------
  // input synchronizer and edge detect
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
      line_q <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], rx_serial};
      line_q <= sync_q[1];
    end
  end

  assign falling   = line_q & ~sync_q[1];
  assign mid_start = tick && (tick_cnt == 4'd7);
  assign mid_bit   = tick && (tick_cnt == 4'd15);
  assign exp_par   = parity_even ? ^shreg : ~^shreg;
  assign rx_data   = shreg;  // held until the next frame's data bits

  always_ff @(posedge apb_if) begin
    if (state == RX_DATA && mid_bit) begin
      shreg <= {sync_q[1], shreg[7:1]};
    end
  end

  // --------------------
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      state         <= RX_IDLE;
      tick_cnt      <= 4'd0;
      bit_idx       <= 3'd0;
      par_err_q     <= 1'b0;
      rx_valid      <= 1'b0;
      rx_parity_err <= 1'b0;
      rx_frame_err  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (state != RX_IDLE && tick) tick_cnt <= tick_cnt + 4'd1;
      case (state)
        RX_IDLE: begin
          tick_cnt  <= 4'd0;
          par_err_q <= 1'b0;
          if (falling) state <= RX_START;
        end
        RX_START: begin
          if (mid_start) begin
            tick_cnt <= 4'd0;  // realign to mid-bit
            bit_idx  <= 3'd0;
            state    <= sync_q[1] ? RX_IDLE : RX_DATA;  // high means glitch
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= parity_en ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (mid_bit) begin
            par_err_q <= sync_q[1] ^ exp_par;
            state     <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (mid_bit) begin
            rx_valid      <= 1'b1;  // byte delivered even with errors
            rx_parity_err <= par_err_q;
            rx_frame_err  <= ~sync_q[1];
            state         <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  logic       apb_if,
  input  logic       rst_n,
  input  logic       tick,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  input  logic       parity_en,
  input  logic       parity_even,
  output logic       tx_serial,
  output logic       tx_busy
);
  import uart_package::*;

  tx_state_e  state;
  logic [3:0] tick_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  logic       par_bit;
  logic       par_en_q;
  logic       bit_end;

  assign bit_end = tick && (tick_cnt == 4'd15);  // 16 ticks per bit

  // payload shifter
  always_ff @(posedge apb_if) begin
    if (state == TX_IDLE && tx_start) begin
      shreg <= tx_data;
    end else if (state == TX_DATA && bit_end) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      tick_cnt  <= 4'd0;
      bit_idx   <= 3'd0;
      par_bit   <= 1'b0;
      par_en_q  <= 1'b0;
      tx_busy   <= 1'b0;
      tx_serial <= 1'b1;
    end else begin
      if (state != TX_IDLE && tick) tick_cnt <= tick_cnt + 4'd1;
      case (state)
        TX_IDLE: begin
          tick_cnt <= 4'd0;
          if (tx_start) begin
            tx_busy  <= 1'b1;
            par_en_q <= parity_en;
            par_bit  <= parity_even ? ^tx_data : ~^tx_data;
          end else if (tx_busy && tick) begin
            state     <= TX_START;  // frame starts on a tick
            tx_serial <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state     <= TX_DATA;
            bit_idx   <= 3'd0;
            tx_serial <= shreg[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx != 3'd7) begin
              bit_idx   <= bit_idx + 3'd1;
              tx_serial <= shreg[1];  // lsb first
            end else if (par_en_q) begin
              state     <= TX_PARITY;
              tx_serial <= par_bit;
            end else begin
              state     <= TX_STOP;
              tx_serial <= 1'b1;
            end
          end
        end
        TX_PARITY: begin
          if (bit_end) begin
            state     <= TX_STOP;
            tx_serial <= 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state   <= TX_IDLE;
            tx_busy <= 1'b0;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  a_idle_mark: assert property (@(posedge apb_if) disable iff (!rst_n)
    (state == TX_IDLE) |-> tx_serial)
    else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

// File: source/uart_baud_gen.sv
`timescale 1ns/1ns
`default_nettype none

module uart_baud_gen (
  input  logic        apb_if,
  input  logic        rst_n,
  input  logic [15:0] divisor,
  output logic        tick
);

  logic [15:0] cnt;
  logic [15:0] reload;

  assign reload = (divisor == 16'd0) ? 16'd1 : divisor;  // zero acts as one

  // counts reload..1, one tick per pass
  always_ff @(posedge apb_if or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= 16'd0;
      tick <= 1'b0;
    end else if (cnt <= 16'd1) begin
      cnt  <= reload;  // new divisor picked up here
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 16'd1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_package.sv
`default_nettype none

`include "uart_config.svh"

package uart_package;

  // apb target phases
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    SETUP  = 2'b01,
    ACCESS = 2'b10
  } apb_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  // register map, byte addresses
  typedef enum logic [`UART_ADDR_WIDTH-1:0] {
    ADDR_TDR = 'h00,
    ADDR_RDR = 'h04,
    ADDR_LCR = 'h08,
    ADDR_OCR = 'h0C,
    ADDR_LSR = 'h10,
    ADDR_FCR = 'h14,
    ADDR_MSR = 'h18,
    ADDR_MCR = 'h1C,
    ADDR_IER = 'h20,
    ADDR_IIR = 'h24
  } reg_addr_e;

endpackage

`default_nettype wire

// File: source/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// bus widths
`define UART_DATA_WIDTH    32
`define UART_ADDR_WIDTH    12

`define UART_RESET_DIVISOR 4  // ocr after reset

// --------------------
// register bit positions
`define UART_LSR_DR        0
`define UART_LSR_PE        2
`define UART_LSR_FE        3
`define UART_LSR_TEMT      5
`define UART_LCR_PEN       3
`define UART_LCR_EPS       4
`define UART_MCR_LOOP      4
`define UART_IER_RX        0
`define UART_IER_TX        1

`endif
